//--- rtl/cpu_pkg.sv
package cpu_pkg;

	localparam int DATA_W     = 32;
	localparam int REG_ADDR_W = 5;
	localparam int ALU_OP_W   = 4;

	localparam logic [ALU_OP_W-1:0] ALU_ADD  = 4'd0;
	localparam logic [ALU_OP_W-1:0] ALU_SUB  = 4'd1;
	localparam logic [ALU_OP_W-1:0] ALU_AND  = 4'd2;
	localparam logic [ALU_OP_W-1:0] ALU_OR   = 4'd3;
	localparam logic [ALU_OP_W-1:0] ALU_XOR  = 4'd4;
	localparam logic [ALU_OP_W-1:0] ALU_NOR  = 4'd5;
	localparam logic [ALU_OP_W-1:0] ALU_SLT  = 4'd6;
	localparam logic [ALU_OP_W-1:0] ALU_SLTU = 4'd7;
	localparam logic [ALU_OP_W-1:0] ALU_SLL  = 4'd8;
	localparam logic [ALU_OP_W-1:0] ALU_SRL  = 4'd9;
	localparam logic [ALU_OP_W-1:0] ALU_SRA  = 4'd10;
	localparam logic [ALU_OP_W-1:0] ALU_LUI  = 4'd11;

	// major opcodes
	localparam logic [5:0] OP_SPECIAL = 6'b000000;
	localparam logic [5:0] OP_J       = 6'b000010;
	localparam logic [5:0] OP_JAL     = 6'b000011;
	localparam logic [5:0] OP_BEQ     = 6'b000100;
	localparam logic [5:0] OP_BNE     = 6'b000101;
	localparam logic [5:0] OP_ADDIU   = 6'b001001;
	localparam logic [5:0] OP_ANDI    = 6'b001100;
	localparam logic [5:0] OP_ORI     = 6'b001101;
	localparam logic [5:0] OP_XORI    = 6'b001110;
	localparam logic [5:0] OP_LUI     = 6'b001111;
	localparam logic [5:0] OP_LW      = 6'b100011;
	localparam logic [5:0] OP_SW      = 6'b101011;

	// function field of OP_SPECIAL
	localparam logic [5:0] FN_SLL  = 6'b000000;
	localparam logic [5:0] FN_SRL  = 6'b000010;
	localparam logic [5:0] FN_SRA  = 6'b000011;
	localparam logic [5:0] FN_JR   = 6'b001000;
	localparam logic [5:0] FN_ADDU = 6'b100001;
	localparam logic [5:0] FN_SUBU = 6'b100011;
	localparam logic [5:0] FN_AND  = 6'b100100;
	localparam logic [5:0] FN_OR   = 6'b100101;
	localparam logic [5:0] FN_XOR  = 6'b100110;
	localparam logic [5:0] FN_NOR  = 6'b100111;
	localparam logic [5:0] FN_SLT  = 6'b101010;
	localparam logic [5:0] FN_SLTU = 6'b101011;

	localparam logic [REG_ADDR_W-1:0] REG_RA = 5'd31;

	typedef union packed {
		struct packed {
			logic [5:0]            opcode;
			logic [REG_ADDR_W-1:0] rs;
			logic [REG_ADDR_W-1:0] rt;
			logic [REG_ADDR_W-1:0] rd;
			logic [4:0]            shamt;
			logic [5:0]            funct;
		} r;
		struct packed {
			logic [5:0]            opcode;
			logic [REG_ADDR_W-1:0] rs;
			logic [REG_ADDR_W-1:0] rt;
			logic [15:0]           imm16;
		} i;
		struct packed {
			logic [5:0]  opcode;
			logic [25:0] index26;
		} j;
	} instr_u;

endpackage

//--- rtl/fetch_unit.sv
`timescale 1ns/10ps

module fetch_unit import cpu_pkg::*; #(
	parameter logic [DATA_W-1:0] RESET_PC = 32'hbfc00000
) (
	input  logic              clk,
	input  logic              resetn,
	input  logic [DATA_W-1:0] inst_sram_rdata,
	input  logic              redirect,
	input  logic [DATA_W-1:0] redirect_pc,
	output logic              inst_sram_en,
	output logic [DATA_W-1:0] inst_sram_addr,
	output logic              id_valid,
	output logic [DATA_W-1:0] id_pc,
	output logic [DATA_W-1:0] id_instr
);

	logic [DATA_W-1:0] pc;
	logic              fetched;

	// pc only moves once fetching has started
	always_ff @(posedge clk)
	begin
		if (!resetn)
		begin
			pc           <= RESET_PC;
			inst_sram_en <= 1'b0;
		end
		else
		begin
			inst_sram_en <= 1'b1;
			if (inst_sram_en)
			begin
				if (redirect)
					pc <= redirect_pc;
				else
					pc <= pc + 32'd4;
			end
		end
	end

	// word in flight is dropped when execute redirects
	always_ff @(posedge clk)
	begin
		if (!resetn)
			fetched <= 1'b0;
		else
			fetched <= inst_sram_en && !redirect;
	end

	always_ff @(posedge clk)
	begin
		id_pc <= pc;
	end

	assign inst_sram_addr = pc;
	assign id_instr       = inst_sram_rdata;

	// the word now in decode is younger than the redirecting branch
	assign id_valid = fetched && !redirect;

	pc_aligned: assert property (@(posedge clk) disable iff (!resetn)
		inst_sram_en |-> pc[1:0] == 2'b00);

endmodule

//--- rtl/decoder.sv
`timescale 1ns/10ps

module decoder import cpu_pkg::*; (
	input  logic                  id_valid,
	input  logic [DATA_W-1:0]     id_pc,
	input  instr_u                id_instr,
	output logic [REG_ADDR_W-1:0] rs_addr,
	output logic [REG_ADDR_W-1:0] rt_addr,
	output logic [REG_ADDR_W-1:0] dest_addr,
	output logic                  reg_write,
	output logic [ALU_OP_W-1:0]   alu_op,
	output logic                  use_imm,
	output logic                  use_shamt,
	output logic [4:0]            shamt,
	output logic [DATA_W-1:0]     imm,
	output logic                  is_load,
	output logic                  is_store,
	output logic                  is_beq,
	output logic                  is_bne,
	output logic                  is_jump,
	output logic                  is_jr,
	output logic                  link,
	output logic [DATA_W-1:0]     target,
	output logic                  dec_valid
);

	logic              zero_ext;
	logic [DATA_W-1:0] imm_sext;
	logic [DATA_W-1:0] pc_plus4;

	assign rs_addr   = id_instr.r.rs;
	assign rt_addr   = id_instr.r.rt;
	assign shamt     = id_instr.r.shamt;
	assign dec_valid = id_valid;

	assign imm_sext = {{(DATA_W-16){id_instr.i.imm16[15]}}, id_instr.i.imm16};
	assign imm      = zero_ext ? {{(DATA_W-16){1'b0}}, id_instr.i.imm16} : imm_sext;

	// no delay slot, so both targets are relative to pc+4
	assign pc_plus4 = id_pc + 32'd4;
	assign target   = is_jump ? {pc_plus4[31:28], id_instr.j.index26, 2'b00}
	                          : pc_plus4 + {imm_sext[DATA_W-3:0], 2'b00};

	always_comb
	begin
		dest_addr = id_instr.i.rt;
		reg_write = 1'b0;
		alu_op    = ALU_ADD;
		use_imm   = 1'b1;
		use_shamt = 1'b0;
		zero_ext  = 1'b0;
		is_load   = 1'b0;
		is_store  = 1'b0;
		is_beq    = 1'b0;
		is_bne    = 1'b0;
		is_jump   = 1'b0;
		is_jr     = 1'b0;
		link      = 1'b0;
		case (id_instr.r.opcode)
			OP_SPECIAL:
			begin
				dest_addr = id_instr.r.rd;
				reg_write = 1'b1;
				use_imm   = 1'b0;
				case (id_instr.r.funct)
					FN_ADDU: alu_op = ALU_ADD;
					FN_SUBU: alu_op = ALU_SUB;
					FN_AND:  alu_op = ALU_AND;
					FN_OR:   alu_op = ALU_OR;
					FN_XOR:  alu_op = ALU_XOR;
					FN_NOR:  alu_op = ALU_NOR;
					FN_SLT:  alu_op = ALU_SLT;
					FN_SLTU: alu_op = ALU_SLTU;
					FN_SLL, FN_SRL, FN_SRA:
					begin
						use_shamt = 1'b1;
						alu_op    = (id_instr.r.funct == FN_SLL) ? ALU_SLL :
						            (id_instr.r.funct == FN_SRL) ? ALU_SRL : ALU_SRA;
					end
					FN_JR:
					begin
						reg_write = 1'b0;
						is_jr     = 1'b1;
					end
					default: reg_write = 1'b0;
				endcase
			end
			OP_ADDIU: reg_write = 1'b1;
			OP_ANDI, OP_ORI, OP_XORI:
			begin
				reg_write = 1'b1;
				zero_ext  = 1'b1;
				alu_op    = (id_instr.r.opcode == OP_ANDI) ? ALU_AND :
				            (id_instr.r.opcode == OP_ORI) ? ALU_OR : ALU_XOR;
			end
			OP_LUI:
			begin
				reg_write = 1'b1;
				alu_op    = ALU_LUI;
			end
			OP_LW:
			begin
				reg_write = 1'b1;
				is_load   = 1'b1;
			end
			OP_SW:  is_store = 1'b1;
			OP_BEQ: is_beq = 1'b1;
			OP_BNE: is_bne = 1'b1;
			OP_J:   is_jump = 1'b1;
			OP_JAL:
			begin
				is_jump   = 1'b1;
				link      = 1'b1;
				reg_write = 1'b1;
				dest_addr = REG_RA;
			end
			// anything else falls through as a no-op
			default: use_imm = 1'b0;
		endcase
	end

endmodule

//--- rtl/reg_file.sv
`timescale 1ns/10ps

module reg_file import cpu_pkg::*; (
	input  logic                  clk,
	input  logic                  resetn,
	input  logic [REG_ADDR_W-1:0] rs_addr,
	input  logic [REG_ADDR_W-1:0] rt_addr,
	input  logic [REG_ADDR_W-1:0] wb_addr,
	input  logic                  wb_we,
	input  logic [DATA_W-1:0]     wb_data,
	output logic [DATA_W-1:0]     rs_data,
	output logic [DATA_W-1:0]     rt_data
);

	logic [DATA_W-1:0] regs [0:31];

	function automatic logic [DATA_W-1:0] read_port(input logic [REG_ADDR_W-1:0] addr);
		if (addr == '0)
			return '0;
		else if (wb_we && wb_addr == addr)
			return wb_data;
		else
			return regs[addr];
	endfunction

	always_ff @(posedge clk)
	begin
		if (wb_we && wb_addr != '0)
			regs[wb_addr] <= wb_data;
	end

	// same-cycle write is visible to the reader
	always_comb
	begin
		rs_data = read_port(rs_addr);
		rt_data = read_port(rt_addr);
	end

	// writeback drops register zero before it gets here
	zero_untouched: assert property (@(posedge clk) disable iff (!resetn)
		wb_we |-> wb_addr != '0);

endmodule

//--- rtl/alu.sv
`timescale 1ns/10ps

module alu import cpu_pkg::*; (
	input  logic [ALU_OP_W-1:0] alu_op,
	input  logic [DATA_W-1:0]   a,
	input  logic [DATA_W-1:0]   b,
	input  logic [4:0]          shamt,
	output logic [DATA_W-1:0]   result
);

	localparam int HALF_W = DATA_W / 2;

	logic signed_lt;
	logic unsigned_lt;

	assign signed_lt   = $signed(a) < $signed(b);
	assign unsigned_lt = a < b;

	always_comb
	begin
		case (alu_op)
			ALU_ADD:  result = a + b;
			ALU_SUB:  result = a - b;
			ALU_AND:  result = a & b;
			ALU_OR:   result = a | b;
			ALU_XOR:  result = a ^ b;
			ALU_NOR:  result = ~(a | b);
			ALU_SLT:  result = {{(DATA_W-1){1'b0}}, signed_lt};
			ALU_SLTU: result = {{(DATA_W-1){1'b0}}, unsigned_lt};
			// shifts act on a, the execute stage routes rt there
			ALU_SLL:  result = a << shamt;
			ALU_SRL:  result = a >> shamt;
			ALU_SRA:  result = $unsigned($signed(a) >>> shamt);
			ALU_LUI:  result = {b[HALF_W-1:0], {HALF_W{1'b0}}};
			default:  result = '0;
		endcase
	end

endmodule

//--- rtl/execute_writeback.sv
`timescale 1ns/10ps

module execute_writeback import cpu_pkg::*; (
	input  logic                  clk,
	input  logic                  resetn,
	input  logic [DATA_W-1:0]     id_pc,
	input  logic [REG_ADDR_W-1:0] rs_addr,
	input  logic [REG_ADDR_W-1:0] rt_addr,
	input  logic [REG_ADDR_W-1:0] dest_addr,
	input  logic                  reg_write,
	input  logic [ALU_OP_W-1:0]   alu_op,
	input  logic                  use_imm,
	input  logic                  use_shamt,
	input  logic [4:0]            shamt,
	input  logic [DATA_W-1:0]     imm,
	input  logic                  is_load,
	input  logic                  is_store,
	input  logic                  is_beq,
	input  logic                  is_bne,
	input  logic                  is_jump,
	input  logic                  is_jr,
	input  logic                  link,
	input  logic [DATA_W-1:0]     target,
	input  logic                  dec_valid,
	input  logic [DATA_W-1:0]     rs_data,
	input  logic [DATA_W-1:0]     rt_data,
	input  logic [DATA_W-1:0]     data_sram_rdata,
	output logic                  redirect,
	output logic [DATA_W-1:0]     redirect_pc,
	output logic                  data_sram_en,
	output logic                  data_sram_we,
	output logic [DATA_W-1:0]     data_sram_addr,
	output logic [DATA_W-1:0]     data_sram_wdata,
	output logic                  wb_we,
	output logic [REG_ADDR_W-1:0] wb_addr,
	output logic [DATA_W-1:0]     wb_data,
	output logic [DATA_W-1:0]     debug_wb_pc,
	output logic                  debug_wb_rf_wen,
	output logic [REG_ADDR_W-1:0] debug_wb_rf_wnum,
	output logic [DATA_W-1:0]     debug_wb_rf_wdata
);

	logic                  ex_valid;
	logic [DATA_W-1:0]     ex_pc;
	logic [REG_ADDR_W-1:0] ex_rs_addr;
	logic [REG_ADDR_W-1:0] ex_rt_addr;
	logic [REG_ADDR_W-1:0] ex_dest;
	logic                  ex_reg_write;
	logic [ALU_OP_W-1:0]   ex_alu_op;
	logic                  ex_use_imm;
	logic                  ex_use_shamt;
	logic [4:0]            ex_shamt;
	logic [DATA_W-1:0]     ex_imm;
	logic                  ex_is_load;
	logic                  ex_is_store;
	logic                  ex_is_beq;
	logic                  ex_is_bne;
	logic                  ex_is_jump;
	logic                  ex_is_jr;
	logic                  ex_link;
	logic [DATA_W-1:0]     ex_target;
	logic [DATA_W-1:0]     ex_rs_data;
	logic [DATA_W-1:0]     ex_rt_data;

	logic [DATA_W-1:0] fwd_rs;
	logic [DATA_W-1:0] fwd_rt;
	logic [DATA_W-1:0] alu_a;
	logic [DATA_W-1:0] alu_b;
	logic [DATA_W-1:0] alu_result;
	logic              taken;

	logic              wb_we_q;
	logic              wb_is_load;
	logic [DATA_W-1:0] wb_result;
	logic [DATA_W-1:0] wb_pc;

	always_ff @(posedge clk)
	begin
		if (!resetn)
			ex_valid <= 1'b0;
		else
			ex_valid <= dec_valid;
	end

	always_ff @(posedge clk)
	begin
		ex_pc        <= id_pc;
		ex_rs_addr   <= rs_addr;
		ex_rt_addr   <= rt_addr;
		ex_dest      <= dest_addr;
		ex_reg_write <= reg_write;
		ex_alu_op    <= alu_op;
		ex_use_imm   <= use_imm;
		ex_use_shamt <= use_shamt;
		ex_shamt     <= shamt;
		ex_imm       <= imm;
		ex_is_load   <= is_load;
		ex_is_store  <= is_store;
		ex_is_beq    <= is_beq;
		ex_is_bne    <= is_bne;
		ex_is_jump   <= is_jump;
		ex_is_jr     <= is_jr;
		ex_link      <= link;
		ex_target    <= target;
		ex_rs_data   <= rs_data;
		ex_rt_data   <= rt_data;
	end

	// older producers are covered by the register file write-through
	assign fwd_rs = (wb_we && wb_addr == ex_rs_addr) ? wb_data : ex_rs_data;
	assign fwd_rt = (wb_we && wb_addr == ex_rt_addr) ? wb_data : ex_rt_data;

	assign alu_a = ex_use_shamt ? fwd_rt : fwd_rs;
	assign alu_b = ex_use_imm ? ex_imm : fwd_rt;

	alu u_alu (
		.alu_op (ex_alu_op),
		.a      (alu_a),
		.b      (alu_b),
		.shamt  (ex_shamt),
		.result (alu_result)
	);

	assign taken       = (ex_is_beq && fwd_rs == fwd_rt) || (ex_is_bne && fwd_rs != fwd_rt);
	assign redirect    = ex_valid && (taken || ex_is_jump || ex_is_jr);
	assign redirect_pc = ex_is_jr ? fwd_rs : ex_target;

	assign data_sram_en    = ex_valid && (ex_is_load || ex_is_store);
	assign data_sram_we    = ex_valid && ex_is_store;
	assign data_sram_addr  = alu_result;
	assign data_sram_wdata = fwd_rt;

	always_ff @(posedge clk)
	begin
		if (!resetn)
			wb_we_q <= 1'b0;
		else
			wb_we_q <= ex_valid && ex_reg_write && ex_dest != '0;
	end

	always_ff @(posedge clk)
	begin
		wb_addr    <= ex_dest;
		wb_is_load <= ex_is_load;
		wb_pc      <= ex_pc;
		wb_result  <= ex_link ? ex_pc + 32'd4 : alu_result;
	end

	// load data arrives while the load sits in writeback
	assign wb_we   = wb_we_q;
	assign wb_data = wb_is_load ? data_sram_rdata : wb_result;

	assign debug_wb_pc       = wb_pc;
	assign debug_wb_rf_wen   = wb_we_q;
	assign debug_wb_rf_wnum  = wb_addr;
	assign debug_wb_rf_wdata = wb_data;

	// a store never leaves a register write behind
	store_no_write: assert property (@(posedge clk) disable iff (!resetn)
		data_sram_we |-> data_sram_en ##1 !wb_we);

endmodule

//--- rtl/cpu_top.sv
`timescale 1ns/10ps

module cpu_top import cpu_pkg::*; #(
	parameter logic [DATA_W-1:0] RESET_PC = 32'hbfc00000
) (
	input  logic                  clk,
	input  logic                  resetn,
	output logic                  inst_sram_en,
	output logic [DATA_W-1:0]     inst_sram_addr,
	input  logic [DATA_W-1:0]     inst_sram_rdata,
	output logic                  data_sram_en,
	output logic                  data_sram_we,
	output logic [DATA_W-1:0]     data_sram_addr,
	output logic [DATA_W-1:0]     data_sram_wdata,
	input  logic [DATA_W-1:0]     data_sram_rdata,
	output logic [DATA_W-1:0]     debug_wb_pc,
	output logic                  debug_wb_rf_wen,
	output logic [REG_ADDR_W-1:0] debug_wb_rf_wnum,
	output logic [DATA_W-1:0]     debug_wb_rf_wdata
);

	logic                  redirect;
	logic [DATA_W-1:0]     redirect_pc;
	logic                  id_valid;
	logic [DATA_W-1:0]     id_pc;
	logic [DATA_W-1:0]     id_instr;
	logic [REG_ADDR_W-1:0] rs_addr;
	logic [REG_ADDR_W-1:0] rt_addr;
	logic [REG_ADDR_W-1:0] dest_addr;
	logic                  reg_write;
	logic [ALU_OP_W-1:0]   alu_op;
	logic                  use_imm;
	logic                  use_shamt;
	logic [4:0]            shamt;
	logic [DATA_W-1:0]     imm;
	logic                  is_load;
	logic                  is_store;
	logic                  is_beq;
	logic                  is_bne;
	logic                  is_jump;
	logic                  is_jr;
	logic                  link;
	logic [DATA_W-1:0]     target;
	logic                  dec_valid;
	logic [DATA_W-1:0]     rs_data;
	logic [DATA_W-1:0]     rt_data;
	logic                  wb_we;
	logic [REG_ADDR_W-1:0] wb_addr;
	logic [DATA_W-1:0]     wb_data;

	fetch_unit #(
		.RESET_PC (RESET_PC)
	) u_fetch (
		.clk             (clk),
		.resetn          (resetn),
		.inst_sram_rdata (inst_sram_rdata),
		.redirect        (redirect),
		.redirect_pc     (redirect_pc),
		.inst_sram_en    (inst_sram_en),
		.inst_sram_addr  (inst_sram_addr),
		.id_valid        (id_valid),
		.id_pc           (id_pc),
		.id_instr        (id_instr)
	);

	decoder u_decoder (
		.id_valid  (id_valid),
		.id_pc     (id_pc),
		.id_instr  (id_instr),
		.rs_addr   (rs_addr),
		.rt_addr   (rt_addr),
		.dest_addr (dest_addr),
		.reg_write (reg_write),
		.alu_op    (alu_op),
		.use_imm   (use_imm),
		.use_shamt (use_shamt),
		.shamt     (shamt),
		.imm       (imm),
		.is_load   (is_load),
		.is_store  (is_store),
		.is_beq    (is_beq),
		.is_bne    (is_bne),
		.is_jump   (is_jump),
		.is_jr     (is_jr),
		.link      (link),
		.target    (target),
		.dec_valid (dec_valid)
	);

	reg_file u_reg_file (
		.clk     (clk),
		.resetn  (resetn),
		.rs_addr (rs_addr),
		.rt_addr (rt_addr),
		.wb_addr (wb_addr),
		.wb_we   (wb_we),
		.wb_data (wb_data),
		.rs_data (rs_data),
		.rt_data (rt_data)
	);

	execute_writeback u_exwb (
		.clk               (clk),
		.resetn            (resetn),
		.id_pc             (id_pc),
		.rs_addr           (rs_addr),
		.rt_addr           (rt_addr),
		.dest_addr         (dest_addr),
		.reg_write         (reg_write),
		.alu_op            (alu_op),
		.use_imm           (use_imm),
		.use_shamt         (use_shamt),
		.shamt             (shamt),
		.imm               (imm),
		.is_load           (is_load),
		.is_store          (is_store),
		.is_beq            (is_beq),
		.is_bne            (is_bne),
		.is_jump           (is_jump),
		.is_jr             (is_jr),
		.link              (link),
		.target            (target),
		.dec_valid         (dec_valid),
		.rs_data           (rs_data),
		.rt_data           (rt_data),
		.data_sram_rdata   (data_sram_rdata),
		.redirect          (redirect),
		.redirect_pc       (redirect_pc),
		.data_sram_en      (data_sram_en),
		.data_sram_we      (data_sram_we),
		.data_sram_addr    (data_sram_addr),
		.data_sram_wdata   (data_sram_wdata),
		.wb_we             (wb_we),
		.wb_addr           (wb_addr),
		.wb_data           (wb_data),
		.debug_wb_pc       (debug_wb_pc),
		.debug_wb_rf_wen   (debug_wb_rf_wen),
		.debug_wb_rf_wnum  (debug_wb_rf_wnum),
		.debug_wb_rf_wdata (debug_wb_rf_wdata)
	);

endmodule

//--- testbench/tb_model.svh
`ifndef TB_MODEL_SVH
`define TB_MODEL_SVH

logic [15:0]       lfsr_state;
logic [DATA_W-1:0] prog [$];
logic [DATA_W-1:0] m_regs [0:31];
logic [DATA_W-1:0] m_dmem [0:255];
logic [DATA_W-1:0] m_pc;

// fibonacci lfsr, taps 16 14 13 11, one step per bit
function automatic logic [15:0] lfsr_bits(input int n);
	logic [15:0] v;
	logic        fb;
	v = '0;
	for (int k = 0; k < n; k++)
	begin
		fb = lfsr_state[15] ^ lfsr_state[13] ^ lfsr_state[12] ^ lfsr_state[10];
		lfsr_state = {lfsr_state[14:0], fb};
		v = {v[14:0], fb};
	end
	return v;
endfunction

function automatic logic [REG_ADDR_W-1:0] pick_reg();
	logic [15:0] v;
	v = lfsr_bits(3);
	return {2'b00, v[2:0]};
endfunction

function automatic logic [4:0] pick_shamt();
	logic [15:0] v;
	v = lfsr_bits(5);
	return v[4:0];
endfunction

function automatic logic [DATA_W-1:0] enc_r(input logic [5:0] funct,
	input logic [4:0] rs, input logic [4:0] rt, input logic [4:0] rd, input logic [4:0] sh);
	instr_u w;
	w.r.opcode = OP_SPECIAL;
	w.r.rs     = rs;
	w.r.rt     = rt;
	w.r.rd     = rd;
	w.r.shamt  = sh;
	w.r.funct  = funct;
	return w;
endfunction

function automatic logic [DATA_W-1:0] enc_i(input logic [5:0] op,
	input logic [4:0] rs, input logic [4:0] rt, input logic [15:0] imm16);
	instr_u w;
	w.i.opcode = op;
	w.i.rs     = rs;
	w.i.rt     = rt;
	w.i.imm16  = imm16;
	return w;
endfunction

function automatic logic [DATA_W-1:0] enc_j(input logic [5:0] op, input logic [DATA_W-1:0] tgt);
	instr_u w;
	w.j.opcode  = op;
	w.j.index26 = tgt[27:2];
	return w;
endfunction

// scrambles every address bit into the word
function automatic logic [DATA_W-1:0] fill_word(input logic [DATA_W-1:0] a);
	return {a[15:0], a[31:16]} ^ (a << 7) ^ 32'h9e3779b9;
endfunction

function automatic logic [DATA_W-1:0] imem_read(input logic [DATA_W-1:0] addr);
	logic [DATA_W-1:0] idx;
	idx = (addr - BOOT_PC) >> 2;
	if (idx < prog.size())
		return prog[idx];
	else
		return '0;
endfunction

// one instruction of the reference model, returns the kind of event
function automatic int tb_model_step(output logic [4:0] num, output logic [DATA_W-1:0] val,
	output logic [DATA_W-1:0] addr);
	instr_u            w;
	logic [DATA_W-1:0] rs;
	logic [DATA_W-1:0] rt;
	logic [DATA_W-1:0] sext;
	logic [DATA_W-1:0] zext;
	logic [DATA_W-1:0] next_pc;
	int                kind;
	w       = imem_read(m_pc);
	rs      = m_regs[w.r.rs];
	rt      = m_regs[w.r.rt];
	sext    = {{16{w.i.imm16[15]}}, w.i.imm16};
	zext    = {16'h0000, w.i.imm16};
	next_pc = m_pc + 4;
	kind    = EV_NONE;
	num     = w.i.rt;
	val     = '0;
	addr    = '0;
	case (w.r.opcode)
		OP_SPECIAL:
		begin
			num  = w.r.rd;
			kind = EV_WRITE;
			case (w.r.funct)
				FN_ADDU: val = rs + rt;
				FN_SUBU: val = rs - rt;
				FN_AND:  val = rs & rt;
				FN_OR:   val = rs | rt;
				FN_XOR:  val = rs ^ rt;
				FN_NOR:  val = ~(rs | rt);
				FN_SLT:  val = {31'b0, $signed(rs) < $signed(rt)};
				FN_SLTU: val = {31'b0, rs < rt};
				FN_SLL:  val = rt << w.r.shamt;
				FN_SRL:  val = rt >> w.r.shamt;
				FN_SRA:  val = $unsigned($signed(rt) >>> w.r.shamt);
				FN_JR:
				begin
					kind    = EV_NONE;
					next_pc = rs;
				end
				default: kind = EV_NONE;
			endcase
		end
		OP_ADDIU: begin kind = EV_WRITE; val = rs + sext; end
		OP_ANDI:  begin kind = EV_WRITE; val = rs & zext; end
		OP_ORI:   begin kind = EV_WRITE; val = rs | zext; end
		OP_XORI:  begin kind = EV_WRITE; val = rs ^ zext; end
		OP_LUI:   begin kind = EV_WRITE; val = {w.i.imm16, 16'h0000}; end
		OP_LW:
		begin
			kind = EV_WRITE;
			addr = rs + sext;
			val  = m_dmem[addr[9:2]];
		end
		OP_SW:
		begin
			kind = EV_STORE;
			addr = rs + sext;
			val  = rt;
			m_dmem[addr[9:2]] = rt;
		end
		OP_BEQ: if (rs == rt) next_pc = m_pc + 4 + (sext << 2);
		OP_BNE: if (rs != rt) next_pc = m_pc + 4 + (sext << 2);
		OP_J:   next_pc = {next_pc[31:28], w.j.index26, 2'b00};
		OP_JAL:
		begin
			kind    = EV_WRITE;
			num     = REG_RA;
			val     = m_pc + 4;
			next_pc = {next_pc[31:28], w.j.index26, 2'b00};
		end
		default: kind = EV_NONE;
	endcase
	if (kind == EV_WRITE && num == 5'd0)
		kind = EV_NONE;
	else if (kind == EV_WRITE)
		m_regs[num] = val;
	m_pc = next_pc;
	return kind;
endfunction

`endif

//--- testbench/tb_cpu.sv
`timescale 1ns/10ps

module tb_cpu import cpu_pkg::*; ;

	localparam int                CLK_PERIOD = 100;
	localparam logic [DATA_W-1:0] BOOT_PC    = 32'hbfc00000;
	localparam logic [15:0]       LFSR_SEED  = 16'd57;
	localparam int                EV_NONE    = 0;
	localparam int                EV_WRITE   = 1;
	localparam int                EV_STORE   = 2;

	logic                  clk;
	logic                  resetn;
	logic                  inst_sram_en;
	logic [DATA_W-1:0]     inst_sram_addr;
	logic [DATA_W-1:0]     inst_sram_rdata;
	logic                  data_sram_en;
	logic                  data_sram_we;
	logic [DATA_W-1:0]     data_sram_addr;
	logic [DATA_W-1:0]     data_sram_wdata;
	logic [DATA_W-1:0]     data_sram_rdata;
	logic [DATA_W-1:0]     debug_wb_pc;
	logic                  debug_wb_rf_wen;
	logic [REG_ADDR_W-1:0] debug_wb_rf_wnum;
	logic [DATA_W-1:0]     debug_wb_rf_wdata;

	logic [DATA_W-1:0]     dmem [0:255];
	logic                  inst_req_en;
	logic [DATA_W-1:0]     inst_req;
	logic [DATA_W-1:0]     data_req;
	int                    exp_kind [$];
	logic [DATA_W-1:0]     exp_pc [$];
	logic [REG_ADDR_W-1:0] exp_num [$];
	logic [DATA_W-1:0]     exp_val [$];
	logic [DATA_W-1:0]     exp_addr [$];
	int                    cycle_count;
	int                    cycle_limit;
	bit                    fetch_seen;

	`include "tb_model.svh"

	cpu_top uut (
		.clk               (clk),
		.resetn            (resetn),
		.inst_sram_en      (inst_sram_en),
		.inst_sram_addr    (inst_sram_addr),
		.inst_sram_rdata   (inst_sram_rdata),
		.data_sram_en      (data_sram_en),
		.data_sram_we      (data_sram_we),
		.data_sram_addr    (data_sram_addr),
		.data_sram_wdata   (data_sram_wdata),
		.data_sram_rdata   (data_sram_rdata),
		.debug_wb_pc       (debug_wb_pc),
		.debug_wb_rf_wen   (debug_wb_rf_wen),
		.debug_wb_rf_wnum  (debug_wb_rf_wnum),
		.debug_wb_rf_wdata (debug_wb_rf_wdata)
	);

	always #(CLK_PERIOD/2) clk = ~clk;

	task automatic report_failure(input string msg);
		$display("%s", msg);
		$display("Finished with errors");
		$fatal(1);
	endtask

	task automatic check_fetch(input logic [DATA_W-1:0] got, input logic [DATA_W-1:0] exp);
		if (got !== exp)
			report_failure($sformatf("mismatch inst_sram_addr: got %h, expected %h", got, exp));
	endtask

	task automatic check_writeback(input logic [DATA_W-1:0] pc, input logic [REG_ADDR_W-1:0] num,
		input logic [DATA_W-1:0] data, input logic [DATA_W-1:0] e_pc,
		input logic [REG_ADDR_W-1:0] e_num, input logic [DATA_W-1:0] e_data);
		if (pc !== e_pc)
			report_failure($sformatf("mismatch debug_wb_pc: got %h, expected %h", pc, e_pc));
		else if (num !== e_num)
			report_failure($sformatf("mismatch debug_wb_rf_wnum: got %h, expected %h", num, e_num));
		else if (data !== e_data)
			report_failure($sformatf("mismatch debug_wb_rf_wdata: got %h, expected %h", data, e_data));
	endtask

	task automatic check_store(input logic [DATA_W-1:0] addr, input logic [DATA_W-1:0] data,
		input logic [DATA_W-1:0] e_addr, input logic [DATA_W-1:0] e_data);
		if (addr !== e_addr)
			report_failure($sformatf("mismatch data_sram_addr: got %h, expected %h", addr, e_addr));
		else if (data !== e_data)
			report_failure($sformatf("mismatch data_sram_wdata: got %h, expected %h", data, e_data));
	endtask

	task automatic build_program();
		logic [5:0]        r_fns [0:7];
		logic [5:0]        s_fns [0:2];
		logic [5:0]        i_ops [0:4];
		logic [DATA_W-1:0] here;
		r_fns = '{FN_ADDU, FN_SUBU, FN_AND, FN_OR, FN_XOR, FN_NOR, FN_SLT, FN_SLTU};
		s_fns = '{FN_SLL, FN_SRL, FN_SRA};
		i_ops = '{OP_ADDIU, OP_ANDI, OP_ORI, OP_XORI, OP_LUI};
		// random operands from a lui and the ori right behind it
		for (logic [4:0] r = 1; r < 8; r++)
		begin
			prog.push_back(enc_i(OP_LUI, 5'd0, r, lfsr_bits(16)));
			prog.push_back(enc_i(OP_ORI, r, r, lfsr_bits(16)));
		end
		for (int n = 0; n < 4; n++)
		begin
			for (int k = 0; k < 8; k++)
				prog.push_back(enc_r(r_fns[k], pick_reg(), pick_reg(), pick_reg(), 5'd0));
			for (int k = 0; k < 3; k++)
				prog.push_back(enc_r(s_fns[k], 5'd0, pick_reg(), pick_reg(), pick_shamt()));
			for (int k = 0; k < 5; k++)
				prog.push_back(enc_i(i_ops[k], pick_reg(), pick_reg(), lfsr_bits(16)));
		end
		// stores, loads and load-use
		prog.push_back(enc_i(OP_ADDIU, 5'd0, 5'd8, 16'h0100));
		prog.push_back(enc_i(OP_SW, 5'd8, 5'd1, 16'd4));
		prog.push_back(enc_i(OP_SW, 5'd8, 5'd2, 16'd8));
		prog.push_back(enc_i(OP_LW, 5'd8, 5'd9, 16'd4));
		prog.push_back(enc_r(FN_ADDU, 5'd9, 5'd9, 5'd10, 5'd0));
		prog.push_back(enc_i(OP_LW, 5'd8, 5'd11, 16'd8));
		prog.push_back(enc_i(OP_SW, 5'd8, 5'd11, 16'd12));
		prog.push_back(enc_i(OP_LW, 5'd8, 5'd12, 16'd12));
		prog.push_back(enc_i(OP_LW, 5'd8, 5'd13, 16'h0040));
		prog.push_back(enc_i(OP_SW, 5'd8, 5'd13, 16'd16));
		// branches
		prog.push_back(enc_i(OP_ADDIU, 5'd0, 5'd15, 16'd5));
		prog.push_back(enc_i(OP_ADDIU, 5'd0, 5'd16, 16'd7));
		prog.push_back(enc_i(OP_BEQ, 5'd15, 5'd16, 16'd1));
		prog.push_back(enc_i(OP_ADDIU, 5'd15, 5'd17, 16'd1));
		prog.push_back(enc_i(OP_BNE, 5'd15, 5'd16, 16'd2));
		prog.push_back(enc_i(OP_ADDIU, 5'd0, 5'd17, 16'h0bad));
		prog.push_back(enc_i(OP_ADDIU, 5'd0, 5'd18, 16'h0bad));
		prog.push_back(enc_i(OP_BEQ, 5'd17, 5'd17, 16'd1));
		prog.push_back(enc_i(OP_ADDIU, 5'd0, 5'd17, 16'h0bad));
		prog.push_back(enc_i(OP_BNE, 5'd16, 5'd16, 16'd1));
		prog.push_back(enc_i(OP_ADDIU, 5'd17, 5'd18, 16'd3));
		here = BOOT_PC + 4 * prog.size();
		prog.push_back(enc_j(OP_J, here + 8));
		prog.push_back(enc_i(OP_ADDIU, 5'd0, 5'd19, 16'h0bad));
		// call, return, then the self-jump
		here = BOOT_PC + 4 * prog.size();
		prog.push_back(enc_j(OP_JAL, here + 12));
		prog.push_back(enc_i(OP_ADDIU, 5'd31, 5'd20, 16'd1));
		prog.push_back(enc_j(OP_J, here + 8));
		prog.push_back(enc_i(OP_ADDIU, 5'd0, 5'd21, 16'd9));
		prog.push_back(enc_r(FN_JR, 5'd31, 5'd0, 5'd0, 5'd0));
	endtask

	task automatic predict_events();
		logic [DATA_W-1:0] pc;
		logic [4:0]        num;
		logic [DATA_W-1:0] val;
		logic [DATA_W-1:0] addr;
		int                kind;
		int                steps;
		m_pc  = BOOT_PC;
		steps = 0;
		while (imem_read(m_pc) != enc_j(OP_J, m_pc) && steps < 10000)
		begin
			pc   = m_pc;
			kind = tb_model_step(num, val, addr);
			if (kind != EV_NONE)
			begin
				exp_kind.push_back(kind);
				exp_pc.push_back(pc);
				exp_num.push_back(num);
				exp_val.push_back(val);
				exp_addr.push_back(addr);
			end
			steps++;
		end
	endtask

	task automatic pop_event();
		void'(exp_kind.pop_front());
		void'(exp_pc.pop_front());
		void'(exp_num.pop_front());
		void'(exp_val.pop_front());
		void'(exp_addr.pop_front());
	endtask

	// memories answer at the falling edge and take requests late in the low phase
	always
	begin
		@(negedge clk);
		inst_sram_rdata = inst_req_en ? imem_read(inst_req) : '0;
		data_sram_rdata = dmem[data_req[9:2]];
		#(CLK_PERIOD/4);
		inst_req_en = inst_sram_en;
		inst_req    = inst_sram_addr;
		if (data_sram_en)
			data_req = data_sram_addr;
		if (data_sram_en && data_sram_we)
			dmem[data_sram_addr[9:2]] = data_sram_wdata;
	end

	always
	begin
		@(negedge clk);
		#(CLK_PERIOD/4);
		if (resetn)
		begin
			if (inst_sram_en && !fetch_seen)
			begin
				fetch_seen = 1'b1;
				check_fetch(inst_sram_addr, BOOT_PC);
			end
			if (debug_wb_rf_wen)
			begin
				if (exp_kind.size() == 0 || exp_kind[0] != EV_WRITE)
					report_failure("register write that the model does not expect");
				else
				begin
					check_writeback(debug_wb_pc, debug_wb_rf_wnum, debug_wb_rf_wdata,
						exp_pc[0], exp_num[0], exp_val[0]);
					pop_event();
				end
			end
			if (data_sram_en && data_sram_we)
			begin
				if (exp_kind.size() == 0 || exp_kind[0] != EV_STORE)
					report_failure("data store that the model does not expect");
				else
				begin
					check_store(data_sram_addr, data_sram_wdata, exp_addr[0], exp_val[0]);
					pop_event();
				end
			end
		end
	end

	always @(posedge clk)
	begin
		cycle_count = cycle_count + 1;
		if (cycle_count > cycle_limit)
			report_failure($sformatf("timeout, program not done after %0d cycles", cycle_limit));
	end

	initial
	begin
		clk             = 1'b0;
		resetn          = 1'b0;
		inst_sram_rdata = '0;
		data_sram_rdata = '0;
		inst_req_en     = 1'b0;
		inst_req        = '0;
		data_req        = '0;
		cycle_count     = 0;
		fetch_seen      = 1'b0;
		lfsr_state      = LFSR_SEED;
		for (int i = 0; i < 256; i++)
		begin
			dmem[i]   = fill_word(i << 2);
			m_dmem[i] = fill_word(i << 2);
		end
		for (int i = 0; i < 32; i++)
			m_regs[i] = '0;
		build_program();
		predict_events();
		cycle_limit = 6 * prog.size() + 20;
		repeat (2) @(negedge clk);
		resetn = 1'b1;
		while (exp_kind.size() != 0)
			@(negedge clk);
		// stray writes after the last expected one
		repeat (6) @(negedge clk);
		$display("Finished with no errors");
		$finish;
	end

endmodule

//--- vlog.f
+incdir+testbench
rtl/cpu_pkg.sv
rtl/fetch_unit.sv
rtl/decoder.sv
rtl/reg_file.sv
rtl/alu.sv
rtl/execute_writeback.sv
rtl/cpu_top.sv
testbench/tb_cpu.sv

//--- run_sim.sh
#!/bin/sh
# builds the testbench with Verilator and runs it
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module tb_cpu -f vlog.f -o tb_cpu_sim

# a failing run ends in $fatal, which gives a nonzero exit status
./obj_dir/tb_cpu_sim
